// ==== verilog/egr_pkg.sv ====
// Egress stage shared definitions
`default_nettype none

package egr_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================

  // Transmit ports in the group
  localparam int NUM_PORTS = 4;
  // Descriptor FIFO entries
  localparam int QUEUE_DEPTH = 8;

  // Field widths
  localparam int PORT_W = 2;
  localparam int SEG_PTR_W = 20;
  localparam int LEN_W = 4;
  localparam int WORD_W = 64;

  // FIFO pointer and occupancy widths
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  // One extra bit so a full queue can be counted
  localparam int QCNT_W = QPTR_W + 1;

  // Control FSM encoding width
  localparam int CTRL_STATE_W = 3;

  // ==========================================================
  // Plain vector types
  // ==========================================================

  // Transmit port index
  typedef logic [PORT_W-1:0] port_t;
  // Word address into shared memory
  typedef logic [SEG_PTR_W-1:0] seg_ptr_t;
  // Packet length in words, zero is illegal
  typedef logic [LEN_W-1:0] len_t;
  // Data word
  typedef logic [WORD_W-1:0] word_t;
  // FIFO slot index
  typedef logic [QPTR_W-1:0] qptr_t;
  // FIFO occupancy
  typedef logic [QCNT_W-1:0] qcnt_t;

  // ==========================================================
  // Structs
  // ==========================================================

  // Packet descriptor from a tag source, 26 bits
  typedef struct packed {
    port_t    port;
    seg_ptr_t seg_ptr;
    len_t     len;
  } egr_tag_t;

  // One transmit port beat, 67 bits
  typedef struct packed {
    logic  valid;
    logic  sop;
    logic  eop;
    word_t data;
  } egr_tx_t;

  // Control FSM states
  typedef enum logic [CTRL_STATE_W-1:0] {
    IDLE,
    LOAD,
    REQ,
    WAIT_DATA,
    WAIT_PORT
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/egr_tag_queue.sv ====
// Egress tag queue
`timescale 1ns/1ns
`default_nettype none

module egr_tag_queue (
  input  logic              egress_clock,
  input  logic              rst,
  input  logic              tag_valid_0,
  input  egr_pkg::egr_tag_t tag_0,
  input  logic              tag_valid_1,
  input  egr_pkg::egr_tag_t tag_1,
  input  logic              q_pop,
  output egr_pkg::egr_tag_t q_head,
  output logic              q_empty,
  output logic              tag_full
);

  // ==========================================================
  // Storage and pointers
  // ==========================================================

  egr_pkg::egr_tag_t mem [egr_pkg::QUEUE_DEPTH];

  egr_pkg::qptr_t wr_ptr_q;
  egr_pkg::qptr_t rd_ptr_q;
  egr_pkg::qcnt_t count_q;
  // Set means source 1 goes first on the next double write
  logic           prio_q;

  // Write order for this cycle
  egr_pkg::egr_tag_t wr_first;
  egr_pkg::egr_tag_t wr_second;
  egr_pkg::qcnt_t    n_wr;
  egr_pkg::qptr_t    wr_ptr_p1;
  logic              do_pop;

  // ==========================================================
  // Merge of the two strobes
  // ==========================================================

  always_comb begin
    wr_first  = tag_0;
    wr_second = tag_1;
    // Both together, alternate who lands first
    if (tag_valid_0 && tag_valid_1 && prio_q) begin
      wr_first  = tag_1;
      wr_second = tag_0;
    end else if (tag_valid_1 && !tag_valid_0) begin
      wr_first = tag_1;
    end
  end

  assign n_wr = egr_pkg::qcnt_t'(tag_valid_0) + egr_pkg::qcnt_t'(tag_valid_1);
  // Second slot wraps with the pointer
  assign wr_ptr_p1 = wr_ptr_q + egr_pkg::qptr_t'(1);
  // Pop on an empty queue is ignored
  assign do_pop = q_pop && !q_empty;

  // Payload writes, no reset on the array
  always_ff @(posedge egress_clock) begin
    if (n_wr != '0) begin
      mem[wr_ptr_q] <= wr_first;
    end
    if (n_wr == egr_pkg::qcnt_t'(2)) begin
      mem[wr_ptr_p1] <= wr_second;
    end
  end

  // Pointer, count and priority update
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      prio_q   <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_q + egr_pkg::qptr_t'(n_wr);
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + egr_pkg::qptr_t'(1);
      end
      count_q <= count_q + n_wr - egr_pkg::qcnt_t'(do_pop);
      // Flip only when both sources collided
      if (tag_valid_0 && tag_valid_1) begin
        prio_q <= ~prio_q;
      end
    end
  end

  // Head is read straight from the array
  assign q_head  = mem[rd_ptr_q];
  assign q_empty = (count_q == '0);
  // Keep two slots in reserve for a double write
  assign tag_full = (count_q > egr_pkg::qcnt_t'(egr_pkg::QUEUE_DEPTH - 2));

endmodule

`default_nettype wire

// ==== verilog/egr_rd_gen.sv ====
// Egress read address generator
`timescale 1ns/1ns
`default_nettype none

module egr_rd_gen (
  input  logic              egress_clock,
  input  logic              rst,
  input  logic              load,
  input  logic              next,
  input  egr_pkg::egr_tag_t q_head,
  output egr_pkg::seg_ptr_t rd_addr,
  output egr_pkg::port_t    cur_port,
  output logic              last
);

  // ==========================================================
  // Current descriptor
  // ==========================================================

  // Address of the word being fetched
  egr_pkg::seg_ptr_t addr_q;
  // Destination of the whole packet
  egr_pkg::port_t    port_q;
  // Words left, including the current one
  egr_pkg::len_t     remain_q;

  // Address and port are payload
  always_ff @(posedge egress_clock) begin
    if (load) begin
      addr_q <= q_head.seg_ptr;
      port_q <= q_head.port;
    end else if (next) begin
      // Step to the following word
      addr_q <= addr_q + egr_pkg::seg_ptr_t'(1);
    end
  end

  // Word counter
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      remain_q <= '0;
    end else if (load) begin
      remain_q <= q_head.len;
    end else if (next && (remain_q != '0)) begin
      remain_q <= remain_q - egr_pkg::len_t'(1);
    end
  end

  // ==========================================================
  // Outputs
  // ==========================================================

  assign rd_addr  = addr_q;
  assign cur_port = port_q;
  // Final word of the packet
  assign last = (remain_q == egr_pkg::len_t'(1));

endmodule

`default_nettype wire

// ==== verilog/egr_ctrl.sv ====
// Egress control FSM
`timescale 1ns/1ns
`default_nettype none

module egr_ctrl (
  input  logic                           egress_clock,
  input  logic                           rst,
  input  logic                           q_empty,
  input  logic                           last,
  input  logic                           rd_data_valid,
  input  logic [egr_pkg::NUM_PORTS-1:0]  port_enable,
  input  egr_pkg::port_t                 cur_port,
  output logic                           q_pop,
  output logic                           load,
  output logic                           next,
  output logic                           rd_req,
  output logic                           emit,
  output logic                           first,
  output logic                           emit_last
);

  // ==========================================================
  // State
  // ==========================================================

  egr_pkg::ctrl_state_t state_q;
  egr_pkg::ctrl_state_t state_d;

  // Next emitted word opens a packet
  logic first_q;
  // Enable of the port the current packet goes to
  logic port_en;

  assign port_en = port_enable[cur_port];

  // ==========================================================
  // Next state and strobes
  // ==========================================================

  always_comb begin
    state_d = state_q;
    q_pop   = 1'b0;
    load    = 1'b0;
    next    = 1'b0;
    rd_req  = 1'b0;
    emit    = 1'b0;

    unique case (state_q)
      egr_pkg::IDLE: begin
        // Start as soon as a tag is queued
        if (!q_empty) begin
          state_d = egr_pkg::LOAD;
        end
      end
      egr_pkg::LOAD: begin
        // Head moves into the read generator
        q_pop   = 1'b1;
        load    = 1'b1;
        state_d = egr_pkg::REQ;
      end
      egr_pkg::REQ: begin
        // Single read, one cycle only
        rd_req  = 1'b1;
        state_d = egr_pkg::WAIT_DATA;
      end
      egr_pkg::WAIT_DATA: begin
        if (rd_data_valid) begin
          if (port_en) begin
            emit = 1'b1;
          end else begin
            // Port stalled, word parks in the holding register
            state_d = egr_pkg::WAIT_PORT;
          end
        end
      end
      egr_pkg::WAIT_PORT: begin
        emit = port_en;
      end
      default: begin
        state_d = egr_pkg::IDLE;
      end
    endcase

    // After a word leaves
    if (emit) begin
      if (last) begin
        // Back to back packets skip IDLE
        state_d = q_empty ? egr_pkg::IDLE : egr_pkg::LOAD;
      end else begin
        next    = 1'b1;
        state_d = egr_pkg::REQ;
      end
    end
  end

  // State and first word flag
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      state_q <= egr_pkg::IDLE;
      first_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load) begin
        first_q <= 1'b1;
      end else if (emit) begin
        first_q <= 1'b0;
      end
    end
  end

  // Flags for the port stage
  assign first     = first_q;
  assign emit_last = last;

endmodule

`default_nettype wire

// ==== verilog/egr_port_tx.sv ====
// Egress transmit port stage
`timescale 1ns/1ns
`default_nettype none

module egr_port_tx (
  input  logic                                      egress_clock,
  input  logic                                      rst,
  input  logic                                      emit,
  input  logic                                      first,
  input  logic                                      emit_last,
  input  egr_pkg::port_t                            cur_port,
  input  logic                                      rd_data_valid,
  input  egr_pkg::word_t                            rd_data,
  output egr_pkg::egr_tx_t [egr_pkg::NUM_PORTS-1:0] tx
);

  // ==========================================================
  // Holding register
  // ==========================================================

  // Last word returned by memory
  egr_pkg::word_t hold_q;
  // Word to send this cycle
  egr_pkg::word_t emit_data;

  always_ff @(posedge egress_clock) begin
    if (rd_data_valid) begin
      hold_q <= rd_data;
    end
  end

  // Same cycle emit bypasses the holding register
  assign emit_data = rd_data_valid ? rd_data : hold_q;

  // ==========================================================
  // Output register
  // ==========================================================

  logic           valid_q;
  logic           sop_q;
  logic           eop_q;
  egr_pkg::word_t data_q;
  egr_pkg::port_t sel_q;

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= emit;
    end
  end

  // Beat payload, only loaded on emit
  always_ff @(posedge egress_clock) begin
    if (emit) begin
      sop_q  <= first;
      eop_q  <= emit_last;
      data_q <= emit_data;
      sel_q  <= cur_port;
    end
  end

  // Fan out, only the selected port sees the beat
  always_comb begin
    for (int p = 0; p < egr_pkg::NUM_PORTS; p++) begin
      tx[p].valid = valid_q && (sel_q == egr_pkg::port_t'(p));
      // Strobes only while the beat is valid
      tx[p].sop   = valid_q && sop_q && (sel_q == egr_pkg::port_t'(p));
      tx[p].eop   = valid_q && eop_q && (sel_q == egr_pkg::port_t'(p));
      tx[p].data  = data_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/egr_top.sv ====
// Egress stage top level
`timescale 1ns/1ns
`default_nettype none

module egr_top (
  input  logic                                      egress_clock,
  input  logic                                      rst,
  input  logic                                      tag_valid_0,
  input  egr_pkg::egr_tag_t                         tag_0,
  input  logic                                      tag_valid_1,
  input  egr_pkg::egr_tag_t                         tag_1,
  output logic                                      tag_full,
  output logic                                      rd_req,
  output egr_pkg::seg_ptr_t                         rd_addr,
  input  logic                                      rd_data_valid,
  input  egr_pkg::word_t                            rd_data,
  input  logic [egr_pkg::NUM_PORTS-1:0]             port_enable,
  output egr_pkg::egr_tx_t [egr_pkg::NUM_PORTS-1:0] tx
);

  // Queue to control
  egr_pkg::egr_tag_t q_head;
  logic              q_empty;
  logic              q_pop;
  // Control to read generator
  logic              load;
  logic              next;
  logic              last;
  egr_pkg::port_t    cur_port;
  // Control to port stage
  logic              emit;
  logic              first;
  logic              emit_last;

  // Descriptor FIFO
  egr_tag_queue queue_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .tag_valid_0  (tag_valid_0),
    .tag_0        (tag_0),
    .tag_valid_1  (tag_valid_1),
    .tag_1        (tag_1),
    .q_pop        (q_pop),
    .q_head       (q_head),
    .q_empty      (q_empty),
    .tag_full     (tag_full)
  );

  // Address and word count
  egr_rd_gen rd_gen_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .load         (load),
    .next         (next),
    .q_head       (q_head),
    .rd_addr      (rd_addr),
    .cur_port     (cur_port),
    .last         (last)
  );

  // Sequencing
  egr_ctrl ctrl_i (
    .egress_clock  (egress_clock),
    .rst           (rst),
    .q_empty       (q_empty),
    .last          (last),
    .rd_data_valid (rd_data_valid),
    .port_enable   (port_enable),
    .cur_port      (cur_port),
    .q_pop         (q_pop),
    .load          (load),
    .next          (next),
    .rd_req        (rd_req),
    .emit          (emit),
    .first         (first),
    .emit_last     (emit_last)
  );

  // Transmit side
  egr_port_tx port_tx_i (
    .egress_clock  (egress_clock),
    .rst           (rst),
    .emit          (emit),
    .first         (first),
    .emit_last     (emit_last),
    .cur_port      (cur_port),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .tx            (tx)
  );

endmodule

`default_nettype wire

// ==== verif/egr_chk.sv ====
// Egress protocol assertions
`timescale 1ns/1ns
`default_nettype none

module egr_chk (
  input  logic                                      egress_clock,
  input  logic                                      rst,
  input  logic                                      rd_req,
  input  logic                                      rd_data_valid,
  input  logic [egr_pkg::NUM_PORTS-1:0]             port_enable,
  input  egr_pkg::egr_tx_t [egr_pkg::NUM_PORTS-1:0] tx
);

  // ==========================================================
  // Tracking state
  // ==========================================================

  logic [egr_pkg::NUM_PORTS-1:0] tx_valid;
  logic [egr_pkg::NUM_PORTS-1:0] tx_sop;
  logic [egr_pkg::NUM_PORTS-1:0] tx_eop;
  // Read issued, answer not yet seen
  logic rd_busy_q;
  // Between sop and eop
  logic pkt_open_q;
  // Failures seen, read by the testbench
  int   fail_count = 0;

  always_comb begin
    for (int p = 0; p < egr_pkg::NUM_PORTS; p++) begin
      tx_valid[p] = tx[p].valid;
      tx_sop[p]   = tx[p].sop;
      tx_eop[p]   = tx[p].eop;
    end
  end

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      rd_busy_q <= 1'b0;
    end else if (rd_req) begin
      rd_busy_q <= 1'b1;
    end else if (rd_data_valid) begin
      rd_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      pkt_open_q <= 1'b0;
    end else if (|tx_valid) begin
      pkt_open_q <= !(|tx_eop);
    end
  end

  // ==========================================================
  // Properties
  // ==========================================================

  // One read in flight
  assert property (@(posedge egress_clock) disable iff (rst) rd_req |-> !rd_busy_q)
    else begin
      $error("rd_req issued while a read was outstanding");
      fail_count++;
    end

  // Single cycle request strobe
  assert property (@(posedge egress_clock) disable iff (rst) rd_req |=> !rd_req)
    else begin
      $error("rd_req held longer than one cycle");
      fail_count++;
    end

  assert property (@(posedge egress_clock) disable iff (rst) $onehot0(tx_valid))
    else begin
      $error("more than one port valid in a cycle");
      fail_count++;
    end

  // Strobes only ride on a valid beat
  assert property (@(posedge egress_clock) disable iff (rst)
                   ((tx_sop | tx_eop) & ~tx_valid) == '0)
    else begin
      $error("sop or eop without valid");
      fail_count++;
    end

  // Beat was emitted while its port was enabled
  assert property (@(posedge egress_clock) disable iff (rst)
                   (tx_valid & ~$past(port_enable)) == '0)
    else begin
      $error("word sent on a disabled port");
      fail_count++;
    end

  // sop opens a packet, other beats continue one
  assert property (@(posedge egress_clock) disable iff (rst)
                   (|tx_valid) |-> ((|tx_sop) == !pkt_open_q))
    else begin
      $error("packet framing broken");
      fail_count++;
    end

endmodule

bind egr_top egr_chk chk_i (
  .egress_clock  (egress_clock),
  .rst           (rst),
  .rd_req        (rd_req),
  .rd_data_valid (rd_data_valid),
  .port_enable   (port_enable),
  .tx            (tx)
);

`default_nettype wire

// ==== verif/egr_tb.sv ====
// Egress stage testbench
`timescale 1ns/1ns
`default_nettype none

module egr_tb;

  // Memory read data rule, address XOR this pattern
  localparam logic [63:0] MEM_PATTERN = 64'h5a3c_96e1_0f7b_d248;
  // Cycles allowed for any single wait
  localparam int TIMEOUT = 2000;

  logic                                      egress_clock;
  logic                                      rst;
  logic                                      tag_valid_0;
  egr_pkg::egr_tag_t                         tag_0;
  logic                                      tag_valid_1;
  egr_pkg::egr_tag_t                         tag_1;
  logic                                      tag_full;
  logic                                      rd_req;
  egr_pkg::seg_ptr_t                         rd_addr;
  logic                                      rd_data_valid;
  egr_pkg::word_t                            rd_data;
  logic [egr_pkg::NUM_PORTS-1:0]             port_enable;
  egr_pkg::egr_tx_t [egr_pkg::NUM_PORTS-1:0] tx;

  integer seed;
  int     err_count;
  int     test_base;
  // Source 1 lands first on the next double strobe
  logic   src1_first;

  // Expected beats per port, and ports in packet start order
  egr_pkg::egr_tx_t exp_q [egr_pkg::NUM_PORTS][$];
  egr_pkg::port_t   order_q [$];

  egr_top dut_i (
    .egress_clock  (egress_clock),
    .rst           (rst),
    .tag_valid_0   (tag_valid_0),
    .tag_0         (tag_0),
    .tag_valid_1   (tag_valid_1),
    .tag_1         (tag_1),
    .tag_full      (tag_full),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .port_enable   (port_enable),
    .tx            (tx)
  );

  // ==========================================================
  // Clock and memory model
  // ==========================================================

  initial begin
    egress_clock = 1'b0;
    forever #50 egress_clock = ~egress_clock;
  end

  function automatic egr_pkg::word_t mem_word(input egr_pkg::seg_ptr_t addr);
    return egr_pkg::word_t'(addr) ^ MEM_PATTERN;
  endfunction

  // One answer per request, 1 to 4 cycles later
  initial begin : responder
    egr_pkg::seg_ptr_t addr;
    int                delay;
    rd_data_valid = 1'b0;
    rd_data       = '0;
    forever begin
      // Request seen mid-cycle, where it is stable
      @(negedge egress_clock);
      rd_data_valid = 1'b0;
      if (rd_req && !rst) begin
        addr  = rd_addr;
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay) @(negedge egress_clock);
        rd_data_valid = 1'b1;
        rd_data       = mem_word(addr);
      end
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================

  function automatic egr_pkg::egr_tag_t make_tag(input int port, input int seg, input int len);
    egr_pkg::egr_tag_t t;
    t.port    = egr_pkg::port_t'(port);
    t.seg_ptr = egr_pkg::seg_ptr_t'(seg);
    t.len     = egr_pkg::len_t'(len);
    return t;
  endfunction

  // Length kept in 1..15
  function automatic egr_pkg::egr_tag_t random_tag();
    egr_pkg::egr_tag_t t;
    t.port    = egr_pkg::port_t'($random(seed));
    t.seg_ptr = egr_pkg::seg_ptr_t'($random(seed));
    t.len     = egr_pkg::len_t'(1 + ($unsigned($random(seed)) % 15));
    return t;
  endfunction

  function automatic int total_errors();
    return err_count + dut_i.chk_i.fail_count;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < egr_pkg::NUM_PORTS; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  // Scoreboard entries for one descriptor
  task automatic expect_packet(input egr_pkg::egr_tag_t tag);
    egr_pkg::egr_tx_t  beat;
    egr_pkg::seg_ptr_t addr;
    for (int i = 0; i < int'(tag.len); i++) begin
      // Address wraps at the pointer width
      addr       = tag.seg_ptr + egr_pkg::seg_ptr_t'(i);
      beat.valid = 1'b1;
      beat.sop   = (i == 0);
      beat.eop   = (i == int'(tag.len) - 1);
      beat.data  = mem_word(addr);
      exp_q[tag.port].push_back(beat);
    end
    order_q.push_back(tag.port);
  endtask

  // One strobe cycle on either or both sources
  task automatic drive_tags(input logic v0, input egr_pkg::egr_tag_t t0,
                            input logic v1, input egr_pkg::egr_tag_t t1);
    int tmo;
    tmo = 0;
    @(negedge egress_clock);
    while (tag_full && tmo < TIMEOUT) begin
      @(negedge egress_clock);
      tmo++;
    end
    if (tag_full) begin
      $display("Timeout at %0t, tag_full never dropped", $time);
      err_count++;
    end else begin
      tag_valid_0 = v0;
      tag_0       = t0;
      tag_valid_1 = v1;
      tag_1       = t1;
      if (v0 && v1) begin
        // Source not favored last time goes first
        if (src1_first) begin
          expect_packet(t1);
          expect_packet(t0);
        end else begin
          expect_packet(t0);
          expect_packet(t1);
        end
        src1_first = !src1_first;
      end else if (v0) begin
        expect_packet(t0);
      end else if (v1) begin
        expect_packet(t1);
      end
      @(negedge egress_clock);
      tag_valid_0 = 1'b0;
      tag_valid_1 = 1'b0;
    end
  endtask

  // Checked on rising edges, away from the monitor
  task automatic wait_drain();
    int tmo;
    tmo = 0;
    while (pending() != 0 && tmo < TIMEOUT) begin
      @(posedge egress_clock);
      tmo++;
    end
    if (pending() != 0) begin
      $display("Timeout at %0t, %0d words never left the DUT", $time, pending());
      err_count++;
    end
    @(negedge egress_clock);
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished with %0d errors", name, total_errors() - test_base);
    test_base = total_errors();
  endtask

  // ==========================================================
  // Scoreboard
  // ==========================================================

  // tx is registered, stable at the falling edge
  always @(negedge egress_clock) begin : monitor
    egr_pkg::egr_tx_t beat;
    if (!rst) begin
      for (int p = 0; p < egr_pkg::NUM_PORTS; p++) begin
        if (tx[p].valid) begin
          if (exp_q[p].size() == 0) begin
            $display("Unexpected word on port %0d at %0t", p, $time);
            err_count++;
          end else begin
            beat = exp_q[p].pop_front();
            assert (tx[p].data == beat.data) else begin
              $display("ERR %0t tx[%0d].data expected %h got %h",
                       $time, p, beat.data, tx[p].data);
              err_count++;
            end
            assert (tx[p].sop == beat.sop) else begin
              $display("ERR %0t tx[%0d].sop expected %b got %b",
                       $time, p, beat.sop, tx[p].sop);
              err_count++;
            end
            assert (tx[p].eop == beat.eop) else begin
              $display("ERR %0t tx[%0d].eop expected %b got %b",
                       $time, p, beat.eop, tx[p].eop);
              err_count++;
            end
            // Packets start in tag order
            if (beat.sop) begin
              assert (order_q.size() != 0 && order_q[0] == egr_pkg::port_t'(p)) else begin
                $display("Packet on port %0d started out of tag order at %0t", p, $time);
                err_count++;
              end
              if (order_q.size() != 0) begin
                void'(order_q.pop_front());
              end
            end
          end
        end
      end
    end
  end

  // ==========================================================
  // Tests
  // ==========================================================

  initial begin : main
    egr_pkg::egr_tag_t t0;
    egr_pkg::egr_tag_t t1;
    int                tmo;
    int                gap;
    int                sel;
    seed        = 32'he151;
    rst         = 1'b1;
    tag_valid_0 = 1'b0;
    tag_0       = '0;
    tag_valid_1 = 1'b0;
    tag_1       = '0;
    port_enable = '1;
    src1_first  = 1'b0;
    err_count   = 0;
    test_base   = 0;
    repeat (2) @(negedge egress_clock);
    rst = 1'b0;

    // Quiet outputs out of reset
    assert (!tag_full && !rd_req && tx[0].valid == 1'b0 && tx[1].valid == 1'b0
            && tx[2].valid == 1'b0 && tx[3].valid == 1'b0) else begin
      $display("Outputs not idle after reset at %0t", $time);
      err_count++;
    end

    // Single word packet
    drive_tags(1'b1, make_tag(2, 'h00100, 1), 1'b0, '0);
    wait_drain();
    report_test("single_word");

    // Mixed lengths over all ports, sources taking turns
    for (int i = 0; i < 8; i++) begin
      t0 = make_tag(i % 4, 'h01000 + i * 32, (i * 5) % 15 + 1);
      if (i % 2 == 0) begin
        drive_tags(1'b1, t0, 1'b0, '0);
      end else begin
        drive_tags(1'b0, '0, 1'b1, t0);
      end
    end
    wait_drain();
    report_test("all_ports");

    // Collisions, order follows the alternation
    for (int i = 0; i < 6; i++) begin
      t0 = make_tag(i % 4, 'h02000 + i * 16, 2);
      t1 = make_tag((i + 2) % 4, 'h03000 + i * 16, 3);
      drive_tags(1'b1, t0, 1'b1, t1);
    end
    wait_drain();
    report_test("collisions");

    // Port 3 stalls after its first word
    drive_tags(1'b1, make_tag(3, 'h04000, 8), 1'b0, '0);
    tmo = 0;
    while (!tx[3].valid && tmo < TIMEOUT) begin
      @(negedge egress_clock);
      tmo++;
    end
    if (!tx[3].valid) begin
      $display("Timeout at %0t, no word ever left port 3", $time);
      err_count++;
    end
    port_enable[3] = 1'b0;
    repeat (15) @(negedge egress_clock);
    port_enable[3] = 1'b1;
    wait_drain();
    report_test("port_stall");

    // All ports held off until the queue fills
    port_enable = '0;
    tmo         = 0;
    while (!tag_full && tmo < 20) begin
      t0 = random_tag();
      t1 = random_tag();
      drive_tags(1'b1, t0, 1'b1, t1);
      tmo++;
    end
    assert (tag_full) else begin
      $display("tag_full never rose with every port stalled");
      err_count++;
    end
    repeat (5) @(negedge egress_clock);
    port_enable = '1;
    // More tags with random gaps, throttled by tag_full
    for (int i = 0; i < 10; i++) begin
      gap = $unsigned($random(seed)) % 3;
      sel = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge egress_clock);
      t0 = random_tag();
      t1 = random_tag();
      drive_tags(sel != 1, t0, sel != 0, t1);
    end
    wait_drain();
    report_test("queue_full");

    $display("Checks done: %0d scoreboard errors, %0d assertion failures",
             err_count, dut_i.chk_i.fail_count);
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/egr_pkg.sv
verilog/egr_tag_queue.sv
verilog/egr_rd_gen.sv
verilog/egr_ctrl.sv
verilog/egr_port_tx.sv
verilog/egr_top.sv
verif/egr_chk.sv
verif/egr_tb.sv

// ==== Bender.yml ====
package:
  name: egr

sources:
  - verilog/egr_pkg.sv
  - verilog/egr_tag_queue.sv
  - verilog/egr_rd_gen.sv
  - verilog/egr_ctrl.sv
  - verilog/egr_port_tx.sv
  - verilog/egr_top.sv
  - target: simulation
    files:
      - verif/egr_chk.sv
      - verif/egr_tb.sv
